//--- src/board_pkg.sv
`default_nettype none

package board_pkg;

  // ====================
  // push keys
  // ====================

  localparam int key_count = 2;  // key[1:0] on the board

  // one bit per key, 1 = released (keys pull low when pressed)
  typedef logic [key_count-1:0] key_vec_t;

  // 1 ms at 50 MHz
  localparam int debounce_default_cycles = 50000;
  localparam int debounce_count_width    = 16;  // holds debounce_default_cycles

  typedef logic [debounce_count_width-1:0] debounce_count_t;

  // ====================
  // heartbeat
  // ====================

  // 0.5 s half period at 50 MHz, so a 1 Hz blink
  localparam int blink_default_half_period = 25000000;
  localparam int blink_count_width         = 26;  // 2**26 > 25e6

  typedef logic [blink_count_width-1:0] blink_count_t;

  // ====================
  // hps reset requests
  // ====================

  // pulse lengths in fpga_clk_50 cycles
  localparam int cold_pulse_cycles  = 6;
  localparam int warm_pulse_cycles  = 2;
  localparam int debug_pulse_cycles = 32;

  // longest pulse is 32, down-counter starts at 31
  localparam int pulse_count_width = 6;

  typedef logic [pulse_count_width-1:0] pulse_count_t;

  // one bit per request type
  // cold sits in bit 0, warm in bit 1, debug in bit 2
  // input side: 1 = requested
  // output side (reset_req_n): 0 = request active toward the hps
  typedef struct packed {
    logic debug;  // bit 2
    logic warm;   // bit 1
    logic cold;   // bit 0
  } reset_req_t;

endpackage

`default_nettype wire

//--- src/key_debounce.sv
`default_nettype none

// two-flop sync then a per-key stability counter
// output bit moves only after the synced key has disagreed with it
// for debounce_cycles edges in a row
module key_debounce #(
  parameter int debounce_cycles = board_pkg::debounce_default_cycles
) (
  input  logic                fpga_clk_50,
  input  logic                hps_fpga_reset_n,
  input  board_pkg::key_vec_t key,      // raw pins, async
  output board_pkg::key_vec_t buttons   // clean, active low
);

  // terminal count, compared against each per-key counter
  localparam board_pkg::debounce_count_t count_limit =
    board_pkg::debounce_count_t'(debounce_cycles);

  // ====================
  // synchronizer
  // ====================

  board_pkg::key_vec_t sync_meta;  // first stage, may go metastable
  board_pkg::key_vec_t sync_q;     // safe to use from here on

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_meta <= '1;  // released
      sync_q    <= '1;
    end
    else
    begin
      sync_meta <= key;
      sync_q    <= sync_meta;
    end
  end

  // ====================
  // per-key counters
  // ====================

  board_pkg::debounce_count_t cnt [board_pkg::key_count];

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt     <= '{default: '0};
      buttons <= '1;  // all keys released out of reset
    end
    else
    begin
      for (int k = 0; k < board_pkg::key_count; k++)
      begin
        if (sync_q[k] == buttons[k])
        begin
          cnt[k] <= '0;  // agree, nothing pending
        end
        else if (cnt[k] == count_limit)
        begin
          // held long enough, accept the new level
          buttons[k] <= sync_q[k];
          cnt[k]     <= '0;
        end
        else
        begin
          cnt[k] <= cnt[k] + 1'b1;  // still disagreeing
        end
      end
    end
  end

  // a bounce that flips back before the limit just clears the count,
  // so short glitches never reach buttons

endmodule

`default_nettype wire

//--- src/reset_pulse_stretcher.sv
`default_nettype none

// one reset-request channel
// rising edge of request -> reset_n low for pulse_cycles cycles
// no retrigger while a pulse runs, falling edge ignored
module reset_pulse_stretcher #(
  parameter int pulse_cycles = board_pkg::cold_pulse_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,   // async level, 1 = requested
  output logic reset_n    // active low pulse to the hps
);

  typedef enum logic {
    st_idle,
    st_pulse
  } state_t;

  // reload value, counter runs down to zero
  localparam board_pkg::pulse_count_t pulse_last =
    board_pkg::pulse_count_t'(pulse_cycles - 1);

  logic [1:0]              sync;    // [0] meta, [1] synced
  logic                    req_q;   // previous synced level
  logic                    rise_q;  // registered rising edge
  state_t                  state;
  board_pkg::pulse_count_t count;

  // ====================
  // sync and edge detect
  // ====================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync   <= '0;
      req_q  <= 1'b0;
      rise_q <= 1'b0;
    end
    else
    begin
      sync   <= {sync[0], request};
      req_q  <= sync[1];
      rise_q <= sync[1] & ~req_q;  // one cycle per 0->1
    end
  end

  // ====================
  // pulse fsm
  // ====================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= st_idle;
      count <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (rise_q)
          begin
            state <= st_pulse;
            count <= pulse_last;
          end
        end
        st_pulse:
        begin
          if (count == '0)
            state <= st_idle;     // pulse done
          else
            count <= count - 1'b1;
          // rise_q ignored here, no retrigger
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign reset_n = (state == st_idle);  // straight off the state flop

endmodule

`default_nettype wire

//--- src/hps_reset_request.sv
`default_nettype none

// cold, warm and debug reset requests toward the hps
// each channel gets its own fixed pulse length
module hps_reset_request (
  input  logic                  fpga_clk_50,
  input  logic                  hps_fpga_reset_n,
  input  board_pkg::reset_req_t reset_req,    // 1 = requested
  output board_pkg::reset_req_t reset_req_n   // 0 = reset requested
);

  logic cold_n;
  logic warm_n;
  logic debug_n;

  reset_pulse_stretcher #(
    .pulse_cycles (board_pkg::cold_pulse_cycles)
  ) cold_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.cold),
    .reset_n          (cold_n)
  );

  reset_pulse_stretcher #(
    .pulse_cycles (board_pkg::warm_pulse_cycles)
  ) warm_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.warm),
    .reset_n          (warm_n)
  );

  reset_pulse_stretcher #(
    .pulse_cycles (board_pkg::debug_pulse_cycles)
  ) debug_stretch (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req.debug),
    .reset_n          (debug_n)
  );

  // repack, same field layout as the input group
  assign reset_req_n = '{
    debug: debug_n,
    warm:  warm_n,
    cold:  cold_n
  };

endmodule

`default_nettype wire

//--- src/heartbeat_blinker.sv
`default_nettype none

// free-running heartbeat, led flips every half_period cycles
module heartbeat_blinker #(
  parameter int half_period = board_pkg::blink_default_half_period
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic heartbeat_led
);

  // last count before the wrap
  localparam board_pkg::blink_count_t count_last =
    board_pkg::blink_count_t'(half_period - 1);

  board_pkg::blink_count_t count;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      count         <= '0;
      heartbeat_led <= 1'b0;  // led off out of reset
    end
    else if (count == count_last)
    begin
      count         <= '0;              // wrap
      heartbeat_led <= ~heartbeat_led;  // toggle once per wrap
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // first toggle lands half_period edges after reset release

endmodule

`default_nettype wire

//--- src/garfield_fpga_top.sv
`default_nettype none

// fpga-side glue of the board
// key debounce, hps reset requests and the heartbeat led
module garfield_fpga_top #(
  parameter int debounce_cycles = board_pkg::debounce_default_cycles,
  parameter int half_period     = board_pkg::blink_default_half_period
) (
  input  logic                  fpga_clk_50,
  input  logic                  hps_fpga_reset_n,  // from the hps, async
  input  board_pkg::key_vec_t   key,               // push keys, active low
  input  board_pkg::reset_req_t reset_req,         // from the debug host
  output board_pkg::key_vec_t   buttons,           // debounced keys
  output board_pkg::reset_req_t reset_req_n,       // to the hps, active low
  output logic                  heartbeat_led
);

  // ====================
  // keys
  // ====================

  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .buttons          (buttons)
  );

  // ====================
  // hps reset requests
  // ====================

  hps_reset_request hps_reset_request_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .reset_req        (reset_req),
    .reset_req_n      (reset_req_n)
  );

  // ====================
  // heartbeat
  // ====================

  heartbeat_blinker #(
    .half_period (half_period)
  ) heartbeat_blinker_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat_led    (heartbeat_led)
  );

endmodule

`default_nettype wire

//--- test/garfield_fpga_checker.sv
`default_nettype none

// concurrent checks on the top-level ports
module garfield_fpga_checker #(
  parameter int debounce_cycles = board_pkg::debounce_default_cycles,
  parameter int half_period     = board_pkg::blink_default_half_period
) (
  input logic                  fpga_clk_50,
  input logic                  hps_fpga_reset_n,
  input board_pkg::key_vec_t   key,
  input board_pkg::reset_req_t reset_req,
  input board_pkg::key_vec_t   buttons,
  input board_pkg::reset_req_t reset_req_n,
  input logic                  heartbeat_led
);

  localparam int follow_edges = debounce_cycles + 2;  // sync stages plus debounce

  int unsigned fail_count = 0;

  logic [2:0]          req_v;    // cold, warm, debug as bits 0..2
  logic [2:0]          req_n_v;
  board_pkg::key_vec_t key_prev;
  int                  stable_len [board_pkg::key_count];  // samples key held its value
  int                  low_len [3];                        // samples field held low
  logic                led_q;
  int                  hb_cnt;                             // edges since last led toggle

  assign req_v   = reset_req;
  assign req_n_v = reset_req_n;

  // ====================
  // helper counters
  // ====================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_prev   <= '1;
      stable_len <= '{default: 0};
      low_len    <= '{default: 0};
      led_q      <= 1'b0;
      hb_cnt     <= 0;
    end
    else
    begin
      for (int k = 0; k < board_pkg::key_count; k++)
      begin
        if (key[k] != key_prev[k])
          stable_len[k] <= 1;  // new value, first sample
        else if (stable_len[k] < follow_edges)
          stable_len[k] <= stable_len[k] + 1;
      end
      for (int c = 0; c < 3; c++)
        low_len[c] <= req_n_v[c] ? 0 : low_len[c] + 1;
      key_prev <= key;
      led_q    <= heartbeat_led;
      hb_cnt   <= (heartbeat_led != led_q) ? 1 : hb_cnt + 1;
    end
  end

  // ====================
  // reset values
  // ====================

  reset_values_a: assert property (@(posedge fpga_clk_50)
    (!hps_fpga_reset_n || $rose(hps_fpga_reset_n)) |->
      (buttons == '1 && reset_req_n == '1 && !heartbeat_led))
  else
  begin
    fail_count++;
    $error("Mismatch at %0t: reset outputs expected 11 111 0 actual %b %b %b",
           $time, buttons, reset_req_n, heartbeat_led);
  end

  // ====================
  // debounce
  // ====================

  for (genvar k = 0; k < board_pkg::key_count; k++)
  begin : key_checks
    // held long enough, button must show it
    follow_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      ($past(stable_len[k]) >= follow_edges) |-> (buttons[k] == $past(key[k], 2)))
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: buttons[%0d] expected %b actual %b",
             $time, k, $past(key[k], 2), buttons[k]);
    end

    // no early move, glitches never pass
    hold_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $changed(buttons[k]) |->
        ($past(stable_len[k]) >= follow_edges && buttons[k] == $past(key[k], 2)))
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: buttons[%0d] expected %b actual %b",
             $time, k, ~buttons[k], buttons[k]);
    end
  end

  // ====================
  // reset pulses
  // ====================

  for (genvar c = 0; c < 3; c++)
  begin : pulse_checks
    localparam int plen = (c == 0) ? board_pkg::cold_pulse_cycles :
                          (c == 1) ? board_pkg::warm_pulse_cycles :
                                     board_pkg::debug_pulse_cycles;

    // onset 3 edges after the sampled rise, and only from idle
    start_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $fell(req_n_v[c]) |-> ($past(req_v[c], 4) && !$past(req_v[c], 5) && $past(req_n_v[c], 4)))
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: reset_req_n[%0d] expected 1 actual 0", $time, c);
    end

    // sampled rise with the field still idle, pulse must start
    onset_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      ($past(req_v[c], 4) && !$past(req_v[c], 5) && $past(req_n_v[c])) |-> !req_n_v[c])
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: reset_req_n[%0d] expected 0 actual 1", $time, c);
    end

    end_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      (low_len[c] == plen) |-> req_n_v[c])
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: reset_req_n[%0d] expected 1 actual 0", $time, c);
    end

    length_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
      $rose(req_n_v[c]) |-> (low_len[c] == plen))
    else
    begin
      fail_count++;
      $error("Mismatch at %0t: reset_req_n[%0d] low cycles expected %0d actual %0d",
             $time, c, plen, low_len[c]);
    end
  end

  // ====================
  // heartbeat
  // ====================

  toggle_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    (heartbeat_led != led_q) |-> (hb_cnt == half_period))
  else
  begin
    fail_count++;
    $error("Mismatch at %0t: heartbeat_led period expected %0d actual %0d",
           $time, half_period, hb_cnt);
  end

  period_a: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    (hb_cnt == half_period) |-> (heartbeat_led != led_q))
  else
  begin
    fail_count++;
    $error("Mismatch at %0t: heartbeat_led expected %b actual %b",
           $time, ~led_q, heartbeat_led);
  end

endmodule

bind garfield_fpga_top garfield_fpga_checker #(
  .debounce_cycles (debounce_cycles),
  .half_period     (half_period)
) checker_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .key              (key),
  .reset_req        (reset_req),
  .buttons          (buttons),
  .reset_req_n      (reset_req_n),
  .heartbeat_led    (heartbeat_led)
);

`default_nettype wire

//--- test/garfield_fpga_tb.sv
`default_nettype none

module garfield_fpga_tb;

  localparam int debounce_cycles = 40;     // short for simulation
  localparam int half_period     = 100;
  localparam int max_cycles      = 12000;  // ~40 key and ~30 request events plus margin

  logic                  fpga_clk_50;
  logic                  hps_fpga_reset_n;
  board_pkg::key_vec_t   key;
  board_pkg::reset_req_t reset_req;
  board_pkg::key_vec_t   buttons;
  board_pkg::reset_req_t reset_req_n;
  logic                  heartbeat_led;

  logic [31:0] lcg_state   = 32'ha8c6;
  int          cycle_count = 0;

  garfield_fpga_top #(
    .debounce_cycles (debounce_cycles),
    .half_period     (half_period)
  ) garfield_fpga_top_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .reset_req        (reset_req),
    .buttons          (buttons),
    .reset_req_n      (reset_req_n),
    .heartbeat_led    (heartbeat_led)
  );

  // ====================
  // clock and limits
  // ====================

  initial fpga_clk_50 = 1'b0;
  always #10 fpga_clk_50 = ~fpga_clk_50;  // 20 units per cycle

  always @(posedge fpga_clk_50)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
    begin
      $display("timeout: stimulus did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  // first assertion failure ends the run
  always @(negedge fpga_clk_50)
  begin
    if (garfield_fpga_top_i.checker_i.fail_count != 0)
    begin
      $display("Test FAILED");
      $fatal(1, "run stopped on assertion failure");
    end
  end

  // ====================
  // stimulus helpers
  // ====================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // lo..hi from the upper lcg bits
  function automatic int pick(input int lo, input int hi);
    logic [31:0] r;
    r = lcg_next();
    return lo + int'({16'd0, r[31:16]}) % (hi - lo + 1);
  endfunction

  task automatic next_edge();
    @(posedge fpga_clk_50);
    #2;  // drive just after the edge
  endtask

  task automatic idle(input int n);
    repeat (n) next_edge();
  endtask

  // stable toggle or a glitch shorter than the debounce time
  task automatic key_event();
    int k;
    int len;
    k = pick(0, board_pkg::key_count - 1);
    next_edge();
    key[k] = ~key[k];
    if (pick(0, 1) == 0)
    begin
      len = pick(1, debounce_cycles - 1);
      idle(len);
      key[k] = ~key[k];  // back before the count expires
    end
    idle(pick(debounce_cycles + 5, debounce_cycles + 30));
  endtask

  // raise one request, optionally drop and raise it again mid-pulse
  task automatic request_event(input int c, input logic retrigger);
    next_edge();
    reset_req[c] = 1'b1;
    if (retrigger)
    begin
      idle(12);
      reset_req[c] = 1'b0;
      idle(3);
      reset_req[c] = 1'b1;  // lands inside the running pulse
    end
    idle(pick(3, 10));
    reset_req[c] = 1'b0;
    idle(pick(45, 60));  // longest pulse plus pipeline fits
  endtask

  // ====================
  // main sequence
  // ====================

  initial
  begin
    int c;
    hps_fpga_reset_n = 1'b1;
    key              = '1;  // released
    reset_req        = '0;
    #1;
    hps_fpga_reset_n = 1'b0;  // real falling edge before the first clock
    repeat (3) @(posedge fpga_clk_50);
    #2;
    hps_fpga_reset_n = 1'b1;

    for (int i = 0; i < 40; i++)
      key_event();

    for (int i = 0; i < 30; i++)
    begin
      c = pick(0, 2);
      request_event(c, 1'b0);
    end

    for (int i = 0; i < 3; i++)
      request_event(2, 1'b1);  // debug is long enough to re-request inside

    idle(2 * half_period);

    if (garfield_fpga_top_i.checker_i.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("Test FAILED");
      $fatal(1, "assertion failures seen");
    end
  end

endmodule

`default_nettype wire

//--- build.f
src/board_pkg.sv
src/key_debounce.sv
src/reset_pulse_stretcher.sv
src/hps_reset_request.sv
src/heartbeat_blinker.sv
src/garfield_fpga_top.sv
test/garfield_fpga_checker.sv
test/garfield_fpga_tb.sv

//--- Makefile
# Verilator build and run of the garfield FPGA testbench

TOP  := garfield_fpga_tb
SRCS := $(wildcard src/*.sv test/*.sv)

.PHONY: all run clean

all: obj_dir/V$(TOP)

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) build.f
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

# error limit raised so the testbench itself reports the first failure
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
